/* src/bip_pkg.sv */
package bip_pkg;

    // ====================
    // Word and field widths
    // ====================

    // Instruction and data word width.
    localparam int NB_DATA    = 16;
    // Upper field of an instruction.
    localparam int NB_OPCODE  = 5;
    // Lower field of an instruction.
    localparam int NB_OPERAND = 11;

    // One data or instruction word.
    typedef logic [NB_DATA-1:0] bip_word_t;

    // ====================
    // Instruction encoding
    // ====================

    // Opcodes of the accumulator machine.
    typedef enum logic [NB_OPCODE-1:0] {
        op_hlt  = 5'd0,
        op_sto  = 5'd1,
        op_ld   = 5'd2,
        op_ldi  = 5'd3,
        op_add  = 5'd4,
        op_addi = 5'd5,
        op_sub  = 5'd6,
        op_subi = 5'd7
    } bip_opcode_t;

    // | 15 opcode 11 | 10 operand 0 |
    typedef struct packed {
        bip_opcode_t             opcode;
        logic [NB_OPERAND-1:0]   operand;
    } bip_instr_t;

    // Decoded controls, only nonzero in the exec cycle.
    typedef struct packed {
        logic wr_acc;
        logic sel_imm;
        logic sel_alu;
        logic sub;
        logic wr_mem;
    } bip_ctrl_t;

    // Fetch/execute sequencer states.
    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_exec,
        st_halt
    } bip_state_t;

endpackage

/* src/instruction_memory.sv */
`timescale 1ns/1ps

module instruction_memory #(
    parameter int N_INSN = 2048
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_enable,
    input  logic [$clog2(N_INSN)-1:0]   i_addr,
    input  logic                        i_we,
    input  logic [$clog2(N_INSN)-1:0]   i_waddr,
    input  bip_pkg::bip_word_t          i_wdata,
    output bip_pkg::bip_word_t          o_data
);

    import bip_pkg::*;

    // ====================
    // Storage
    // ====================

    // Program words, filled through the load port.
    bip_word_t mem_bank [N_INSN];

    // Registered read word.
    bip_word_t data;

    // ====================
    // Load port
    // ====================

    // Written only while the core is stopped.
    always_ff @(posedge i_clock) begin
        if (i_we) begin
            mem_bank[i_waddr] <= i_wdata;
        end
    end

    // ====================
    // Fetch port
    // ====================

    // Reset preloads word 0.
    // Otherwise the word at the PC is captured in fetch.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            data <= mem_bank[0];
        end else if (i_enable) begin
            data <= mem_bank[i_addr];
        end
    end

    assign o_data = data;

endmodule

/* src/data_memory.sv */
`timescale 1ns/1ps

module data_memory #(
    parameter int N_DATA_WORDS = 1024
) (
    input  logic                               i_clock,
    input  logic [$clog2(N_DATA_WORDS)-1:0]    i_addr,
    input  logic                               i_we,
    input  bip_pkg::bip_word_t                 i_wdata,
    output bip_pkg::bip_word_t                 o_rdata
);

    import bip_pkg::*;

    // ====================
    // Storage
    // ====================

    // Data words, undefined until stored.
    bip_word_t mem_bank [N_DATA_WORDS];

    // ====================
    // Access
    // ====================

    // Read is combinational.
    // LD and ADD see the word within the exec cycle.
    assign o_rdata = mem_bank[i_addr];

    // STO writes the accumulator at the end of exec.
    always_ff @(posedge i_clock) begin
        if (i_we) begin
            mem_bank[i_addr] <= i_wdata;
        end
    end

endmodule

/* src/bip_control.sv */
`timescale 1ns/1ps

module bip_control #(
    parameter int N_INSN = 2048
) (
    input  logic                              i_clock,
    input  logic                              i_reset,
    input  logic                              i_start,
    input  bip_pkg::bip_instr_t               i_instr,
    input  logic                              i_load_we,
    output logic [$clog2(N_INSN)-1:0]         o_imem_addr,
    output logic                              o_imem_enable,
    output logic                              o_imem_we,
    output bip_pkg::bip_ctrl_t                o_ctrl,
    output logic [bip_pkg::NB_OPERAND-1:0]    o_operand,
    output logic                              o_retire,
    output logic                              o_halt,
    output logic [$clog2(N_INSN)-1:0]         o_pc
);

    import bip_pkg::*;

    // PC width.
    localparam int NB_PC = $clog2(N_INSN);

    // ====================
    // Internal signals
    // ====================

    bip_state_t        state;
    bip_state_t        state_next;
    logic [NB_PC-1:0]  pc;
    logic              retire;
    // Core not running, so loading and starting are allowed.
    logic              stopped;
    logic              start_ok;
    logic              is_hlt;
    bip_ctrl_t         ctrl;

    assign stopped  = (state == st_idle) || (state == st_halt);
    assign start_ok = i_start && stopped;
    assign is_hlt   = (i_instr.opcode == op_hlt);

    // ====================
    // Sequencer
    // ====================

    // Fetch and exec alternate; one instruction in flight.
    always_comb begin
        state_next = state;
        case (state)
            st_idle, st_halt: begin
                if (i_start) begin
                    state_next = st_fetch;
                end
            end
            st_fetch: state_next = st_exec;
            st_exec:  state_next = is_hlt ? st_halt : st_fetch;
            default:  state_next = st_idle;
        endcase
    end

    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    // Start clears the PC.
    // It steps once per instruction, at the end of exec.
    always_ff @(posedge i_clock) begin
        if (i_reset || start_ok) begin
            pc <= '0;
        end else if (state == st_exec) begin
            pc <= pc + NB_PC'(1);
        end
    end

    // Retire pulse lands in the cycle after exec.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            retire <= 1'b0;
        end else begin
            retire <= (state == st_exec);
        end
    end

    // ====================
    // Decoder
    // ====================

    // Controls stay zero outside exec.
    // Unused opcodes fall through as no-ops.
    always_comb begin
        ctrl = '0;
        if (state == st_exec) begin
            case (i_instr.opcode)
                op_sto:  ctrl.wr_mem = 1'b1;
                op_ld:   ctrl.wr_acc = 1'b1;
                op_ldi: begin
                    ctrl.wr_acc  = 1'b1;
                    ctrl.sel_imm = 1'b1;
                end
                op_add: begin
                    ctrl.wr_acc  = 1'b1;
                    ctrl.sel_alu = 1'b1;
                end
                op_addi: begin
                    ctrl.wr_acc  = 1'b1;
                    ctrl.sel_alu = 1'b1;
                    ctrl.sel_imm = 1'b1;
                end
                op_sub: begin
                    ctrl.wr_acc  = 1'b1;
                    ctrl.sel_alu = 1'b1;
                    ctrl.sub     = 1'b1;
                end
                op_subi: begin
                    ctrl.wr_acc  = 1'b1;
                    ctrl.sel_alu = 1'b1;
                    ctrl.sel_imm = 1'b1;
                    ctrl.sub     = 1'b1;
                end
                default: ctrl = '0;
            endcase
        end
    end

    // ====================
    // Outputs
    // ====================

    assign o_imem_addr   = pc;
    assign o_imem_enable = (state == st_fetch);
    // Program load only reaches memory while stopped.
    assign o_imem_we     = i_load_we && stopped;
    assign o_ctrl        = ctrl;
    assign o_operand     = i_instr.operand;
    assign o_retire      = retire;
    assign o_halt        = (state == st_halt);
    assign o_pc          = pc;

endmodule

/* src/bip_datapath.sv */
`timescale 1ns/1ps

module bip_datapath (
    input  logic                              i_clock,
    input  logic                              i_reset,
    input  bip_pkg::bip_ctrl_t                i_ctrl,
    input  logic [bip_pkg::NB_OPERAND-1:0]    i_operand,
    input  bip_pkg::bip_word_t                i_mem_rdata,
    output bip_pkg::bip_word_t                o_acc
);

    import bip_pkg::*;

    // Bits added above the operand by sign extension.
    localparam int NB_EXT = NB_DATA - NB_OPERAND;

    // ====================
    // Internal signals
    // ====================

    // Accumulator register.
    bip_word_t acc;
    // Sign-extended immediate.
    bip_word_t imm;
    // Second operand, immediate or memory.
    bip_word_t operand_b;
    // Add or subtract result.
    bip_word_t alu_result;
    // Value offered to the accumulator.
    bip_word_t acc_next;

    // ====================
    // Operand select
    // ====================

    // Operand bit 10 fills the upper bits.
    assign imm = {{NB_EXT{i_operand[NB_OPERAND-1]}}, i_operand};

    // LDI/ADDI/SUBI use the immediate.
    // LD/ADD/SUB use the memory word.
    assign operand_b = i_ctrl.sel_imm ? imm : i_mem_rdata;

    // ====================
    // Add/subtract unit
    // ====================

    // Both wrap modulo 2^16.
    always_comb begin
        if (i_ctrl.sub) begin
            alu_result = acc - operand_b;
        end else begin
            alu_result = acc + operand_b;
        end
    end

    // Loads bypass the adder.
    assign acc_next = i_ctrl.sel_alu ? alu_result : operand_b;

    // ====================
    // Accumulator
    // ====================

    // Written at the end of exec when wr_acc is set.
    always_ff @(posedge i_clock) begin
        if (i_reset) begin
            acc <= '0;
        end else if (i_ctrl.wr_acc) begin
            acc <= acc_next;
        end
    end

    // Also the store data for STO.
    assign o_acc = acc;

endmodule

/* src/bip_cpu.sv */
`timescale 1ns/1ps

module bip_cpu #(
    parameter int N_INSN       = 2048,
    parameter int N_DATA_WORDS = 1024
) (
    input  logic                        i_clock,
    input  logic                        i_reset,
    input  logic                        i_start,
    input  logic                        i_load_we,
    input  logic [$clog2(N_INSN)-1:0]   i_load_addr,
    input  bip_pkg::bip_word_t          i_load_data,
    output bip_pkg::bip_word_t          o_acc,
    output logic [$clog2(N_INSN)-1:0]   o_pc,
    output logic                        o_retire,
    output logic                        o_halt
);

    import bip_pkg::*;

    localparam int NB_PC    = $clog2(N_INSN);
    localparam int NB_DADDR = $clog2(N_DATA_WORDS);

    // ====================
    // Interconnect
    // ====================

    logic [NB_PC-1:0]       imem_addr;
    logic                   imem_enable;
    logic                   imem_we;
    bip_word_t              imem_data;
    bip_ctrl_t              ctrl;
    logic [NB_OPERAND-1:0]  operand;
    bip_word_t              dmem_rdata;
    bip_word_t              acc;

    // PC, sequencer and decoder.
    bip_control #(
        .N_INSN (N_INSN)
    ) u_control (
        .i_clock       (i_clock),
        .i_reset       (i_reset),
        .i_start       (i_start),
        .i_instr       (bip_instr_t'(imem_data)),
        .i_load_we     (i_load_we),
        .o_imem_addr   (imem_addr),
        .o_imem_enable (imem_enable),
        .o_imem_we     (imem_we),
        .o_ctrl        (ctrl),
        .o_operand     (operand),
        .o_retire      (o_retire),
        .o_halt        (o_halt),
        .o_pc          (o_pc)
    );

    // Accumulator and add/subtract unit.
    bip_datapath u_datapath (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_ctrl      (ctrl),
        .i_operand   (operand),
        .i_mem_rdata (dmem_rdata),
        .o_acc       (acc)
    );

    // Program store with load port.
    instruction_memory #(
        .N_INSN (N_INSN)
    ) u_imem (
        .i_clock  (i_clock),
        .i_reset  (i_reset),
        .i_enable (imem_enable),
        .i_addr   (imem_addr),
        .i_we     (imem_we),
        .i_waddr  (i_load_addr),
        .i_wdata  (i_load_data),
        .o_data   (imem_data)
    );

    // Operand low bits address the data store.
    data_memory #(
        .N_DATA_WORDS (N_DATA_WORDS)
    ) u_dmem (
        .i_clock (i_clock),
        .i_addr  (operand[NB_DADDR-1:0]),
        .i_we    (ctrl.wr_mem),
        .i_wdata (acc),
        .o_rdata (dmem_rdata)
    );

    assign o_acc = acc;

endmodule

/* dv/bip_cpu_checker.sv */
`timescale 1ns/1ps

module bip_cpu_checker #(
    parameter int N_INSN = 2048
) (
    input  logic                         i_clock,
    input  logic                         i_reset,
    input  logic                         i_start,
    input  bip_pkg::bip_state_t          i_state,
    input  logic [$clog2(N_INSN)-1:0]    i_pc,
    input  logic                         i_retire,
    input  logic                         i_imem_we
);

    import bip_pkg::*;

    // ====================
    // Control protocol
    // ====================

    // Retire is a single-cycle pulse.
    assert property (@(posedge i_clock) disable iff (i_reset) i_retire |=> !i_retire)
        else $error("retire held high for more than one cycle");

    // PC holds from fetch through exec.
    assert property (@(posedge i_clock) disable iff (i_reset)
        (i_state == st_exec) |-> $stable(i_pc))
        else $error("PC moved during exec");

    // Program writes only while stopped.
    assert property (@(posedge i_clock) disable iff (i_reset)
        i_imem_we |-> (i_state == st_idle || i_state == st_halt))
        else $error("instruction memory written while running");

    // Halt is left only by start.
    assert property (@(posedge i_clock) disable iff (i_reset)
        (i_state == st_halt && !i_start) |=> (i_state == st_halt))
        else $error("left halt without start");

endmodule

bind bip_control bip_cpu_checker #(
    .N_INSN (N_INSN)
) i_checker (
    .i_clock   (i_clock),
    .i_reset   (i_reset),
    .i_start   (i_start),
    .i_state   (state),
    .i_pc      (pc),
    .i_retire  (o_retire),
    .i_imem_we (o_imem_we)
);

/* dv/bip_cpu_tb.sv */
`timescale 1ns/1ps

module bip_cpu_tb;

    import bip_pkg::*;

    localparam int N_INSN       = 2048;
    localparam int N_DATA_WORDS = 1024;
    localparam int NB_PC        = $clog2(N_INSN);
    localparam int N_TESTS      = 4;
    localparam int MAX_LEN      = 16;
    localparam int RESET_CYCLES = 5;
    // Cycles watched after HLT.
    localparam int HALT_WATCH   = 20;

    // One program word and the accumulator after it retires.
    typedef struct packed {
        bip_word_t insn;
        bip_word_t acc;
    } step_t;

    // ====================
    // DUT
    // ====================

    logic               i_clock;
    logic               i_reset;
    logic               i_start;
    logic               i_load_we;
    logic [NB_PC-1:0]   i_load_addr;
    bip_word_t          i_load_data;
    bip_word_t          o_acc;
    logic [NB_PC-1:0]   o_pc;
    logic               o_retire;
    logic               o_halt;

    bip_cpu #(
        .N_INSN       (N_INSN),
        .N_DATA_WORDS (N_DATA_WORDS)
    ) i_bip_cpu (
        .i_clock     (i_clock),
        .i_reset     (i_reset),
        .i_start     (i_start),
        .i_load_we   (i_load_we),
        .i_load_addr (i_load_addr),
        .i_load_data (i_load_data),
        .o_acc       (o_acc),
        .o_pc        (o_pc),
        .o_retire    (o_retire),
        .o_halt      (o_halt)
    );

    initial begin
        i_clock = 1'b0;
        forever #5 i_clock = ~i_clock;
    end

    // ====================
    // Tables
    // ====================

    step_t  step_tab [N_TESTS][MAX_LEN];
    int     len_tab [N_TESTS];
    string  name_tab [N_TESTS];
    // Retire count after which a load is tried mid-run, -1 for none.
    int     poke_tab [N_TESTS];
    int     poke_addr_tab [N_TESTS];
    logic   tables_ready = 1'b0;

    int check_count = 0;
    int error_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;

    // Opcode in the top 5 bits, operand below.
    function automatic bip_word_t encode(input bip_opcode_t op, input int operand);
        bip_instr_t insn;
        insn.opcode  = op;
        insn.operand = NB_OPERAND'(operand);
        return bip_word_t'(insn);
    endfunction

    function automatic void add_step(input int t, input bip_opcode_t op,
                                     input int operand, input int acc);
        step_tab[t][len_tab[t]].insn = encode(op, operand);
        step_tab[t][len_tab[t]].acc  = bip_word_t'(acc);
        len_tab[t]++;
    endfunction

    function automatic void fill_tables();
        for (int t = 0; t < N_TESTS; t++) begin
            len_tab[t]  = 0;
            poke_tab[t] = -1;
            poke_addr_tab[t] = 0;
        end
        // Prologue seeds mem[1]=5 and mem[2]=3.
        name_tab[0] = "reference program";
        add_step(0, op_ldi, 5, 'h0005);
        add_step(0, op_sto, 1, 'h0005);
        add_step(0, op_ldi, 3, 'h0003);
        add_step(0, op_sto, 2, 'h0003);
        add_step(0, op_ld, 1, 'h0005);
        add_step(0, op_addi, 2, 'h0007);
        add_step(0, op_sto, 7, 'h0007);
        add_step(0, op_ldi, 8, 'h0008);
        add_step(0, op_sub, 2, 'h0005);
        add_step(0, op_add, 2, 'h0008);
        add_step(0, op_sto, 11, 'h0008);
        add_step(0, op_ldi, 3, 'h0003);
        add_step(0, op_subi, 3, 'h0000);
        add_step(0, op_hlt, 0, 'h0000);
        // Bit 10 of the operand is the sign.
        name_tab[1] = "immediate sign extension";
        add_step(1, op_ldi, 'h7FF, 'hFFFF);
        add_step(1, op_addi, 'h001, 'h0000);
        add_step(1, op_subi, 'h001, 'hFFFF);
        add_step(1, op_ldi, 'h400, 'hFC00);
        add_step(1, op_subi, 'h401, 'hFFFF);
        add_step(1, op_addi, 'h3FF, 'h03FE);
        add_step(1, op_ldi, 'h3FF, 'h03FF);
        add_step(1, op_addi, 'h7FF, 'h03FE);
        add_step(1, op_hlt, 0, 'h03FE);
        name_tab[2] = "store/load round trip";
        add_step(2, op_ldi, 'h2A5, 'h02A5);
        add_step(2, op_sto, 3, 'h02A5);
        add_step(2, op_sto, 100, 'h02A5);
        add_step(2, op_sto, 1023, 'h02A5);
        add_step(2, op_ldi, 0, 'h0000);
        add_step(2, op_ld, 100, 'h02A5);
        add_step(2, op_ldi, 0, 'h0000);
        add_step(2, op_add, 3, 'h02A5);
        add_step(2, op_add, 1023, 'h054A);
        add_step(2, op_sub, 100, 'h02A5);
        add_step(2, op_hlt, 0, 'h02A5);
        // A HLT written over word 4 mid-run must be ignored.
        name_tab[3] = "reload and restart";
        poke_tab[3] = 1;
        poke_addr_tab[3] = 4;
        add_step(3, op_ldi, 'h100, 'h0100);
        add_step(3, op_addi, 'h011, 'h0111);
        add_step(3, op_addi, 'h011, 'h0122);
        add_step(3, op_subi, 'h022, 'h0100);
        add_step(3, op_sto, 5, 'h0100);
        add_step(3, op_add, 5, 'h0200);
        add_step(3, op_hlt, 0, 'h0200);
    endfunction

    // ====================
    // Compare tasks
    // ====================

    task automatic compare_word(input string name, input bip_word_t got, input bip_word_t exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s = %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic compare_pc(input string name, input logic [NB_PC-1:0] got,
                              input logic [NB_PC-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("Error at %0t: %s = %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    // ====================
    // Test sequence
    // ====================

    task automatic load_while_running(input int t);
        @(posedge i_clock);
        i_load_we   <= 1'b1;
        i_load_addr <= NB_PC'(poke_addr_tab[t]);
        i_load_data <= encode(op_hlt, 0);
        @(posedge i_clock);
        i_load_we   <= 1'b0;
    endtask

    task automatic run_test(input int t);
        int n;
        int errors_before;
        bip_word_t final_acc;
        errors_before = error_count;
        // Load while idle or halted.
        for (int i = 0; i < len_tab[t]; i++) begin
            @(posedge i_clock);
            i_load_we   <= 1'b1;
            i_load_addr <= NB_PC'(i);
            i_load_data <= step_tab[t][i].insn;
        end
        @(posedge i_clock);
        i_load_we <= 1'b0;
        i_start   <= 1'b1;
        @(posedge i_clock);
        i_start   <= 1'b0;
        // Sampled at the falling edge.
        n = 0;
        while (n < len_tab[t]) begin
            @(negedge i_clock);
            if (o_retire) begin
                compare_word("o_acc", o_acc, step_tab[t][n].acc);
                compare_pc("o_pc", o_pc, NB_PC'(n + 1));
                n++;
                if (n == poke_tab[t]) begin
                    load_while_running(t);
                end
            end
        end
        compare_bit("o_halt", o_halt, 1'b1);
        // Quiet halt with the accumulator held.
        final_acc = step_tab[t][len_tab[t]-1].acc;
        repeat (HALT_WATCH) begin
            @(negedge i_clock);
            compare_bit("o_retire", o_retire, 1'b0);
            compare_bit("o_halt", o_halt, 1'b1);
            compare_word("o_acc", o_acc, final_acc);
        end
        if (error_count == errors_before) begin
            tests_passed++;
        end else begin
            tests_failed++;
        end
        $display("test %0d (%s): %s, %0d errors", t, name_tab[t],
                 (error_count == errors_before) ? "pass" : "fail", error_count - errors_before);
    endtask

    initial begin : main
        $timeformat(-9, 0, " ns", 0);
        i_reset     = 1'b1;
        i_start     = 1'b0;
        i_load_we   = 1'b0;
        i_load_addr = '0;
        i_load_data = '0;
        fill_tables();
        tables_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge i_clock);
        i_reset <= 1'b0;
        // Idle state after reset.
        @(negedge i_clock);
        compare_bit("o_halt", o_halt, 1'b0);
        compare_bit("o_retire", o_retire, 1'b0);
        compare_word("o_acc", o_acc, '0);
        compare_pc("o_pc", o_pc, '0);
        for (int t = 0; t < N_TESTS; t++) begin
            run_test(t);
        end
        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Budget per test covers loading, two cycles per instruction and the halt watch.
    initial begin : watchdog
        int limit;
        wait (tables_ready);
        limit = RESET_CYCLES + 10;
        for (int t = 0; t < N_TESTS; t++) begin
            limit += len_tab[t] * 2 + 50 + len_tab[t] + HALT_WATCH;
        end
        repeat (limit) @(posedge i_clock);
        $display("Timeout: the core stopped retiring before all tests finished");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

/* bip_cpu.f */
src/bip_pkg.sv
src/instruction_memory.sv
src/data_memory.sv
src/bip_control.sv
src/bip_datapath.sv
src/bip_cpu.sv
dv/bip_cpu_checker.sv
dv/bip_cpu_tb.sv

/* Makefile */
# Verilator build and run for the BIP accumulator core.

VERILATOR ?= verilator
TOP       ?= bip_cpu_tb
FILELIST  ?= bip_cpu.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell grep -v '^+' $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^ALL CHECKS PASSED$$" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
